// ==== build.f ====
+incdir+logic
logic/mm_pkg.sv
logic/score_if.sv
logic/button_conditioner.sv
logic/secret_generator.sv
logic/guess_scorer.sv
logic/board_memory.sv
logic/game_control.sv
logic/mastermind_top.sv
verification/mastermind_props.sv
verification/tb_mastermind.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = tb_mastermind
FILELIST = build.f
OBJ_DIR  = obj_dir
SIM_BIN  = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST)) logic/mm_consts.svh
LOG      = sim.log

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST PASSED" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/tb_mastermind.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mm_consts.svh"

module tb_mastermind;

	localparam int PIN_W       = 3;
	localparam int HOLD_CYCLES = 2 * `MM_DEBOUNCE_CYCLES;
	localparam int MAX_CYCLES  = 20000; // Sequence needs roughly 2500 cycles

	logic                   CLK_PLL;
	logic                   rst_n;
	logic [`MM_BUTTONS-1:0] btn_n;  // Raw buttons that read low when pressed
	mm_pkg::board_addr_t    board_rd_addr;
	mm_pkg::game_state_e    game_state;
	mm_pkg::cursor_t        cursor;
	mm_pkg::guess_count_t   guess_count;
	logic                   scoring_busy;
	logic                   guess_scored;
	mm_pkg::board_word_t    board_rd_data;

	int            error_count;
	int            cycle_count = 0;
	int            seed;
	mm_pkg::lfsr_t model_lfsr;
	mm_pkg::code_t model_secret;
	mm_pkg::code_t model_guess;
	mm_pkg::code_t row0_guess;   // Row 0 content before the commit

	mastermind_top i_mastermind_top (
		.CLK_PLL       (CLK_PLL),
		.rst_n         (rst_n),
		.btn_left      (btn_n[`MM_BTN_LEFT]),
		.btn_right     (btn_n[`MM_BTN_RIGHT]),
		.btn_up        (btn_n[`MM_BTN_UP]),
		.btn_down      (btn_n[`MM_BTN_DOWN]),
		.btn_enter     (btn_n[`MM_BTN_ENTER]),
		.board_rd_addr (board_rd_addr),
		.game_state    (game_state),
		.cursor        (cursor),
		.guess_count   (guess_count),
		.scoring_busy  (scoring_busy),
		.guess_scored  (guess_scored),
		.board_rd_data (board_rd_data)
	);

	initial begin
		CLK_PLL = 1'b0;
		forever #5 CLK_PLL = ~CLK_PLL;
	end

	always @(posedge CLK_PLL) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == MAX_CYCLES) begin
			$display("Timeout: no verdict after %0d clock cycles", MAX_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	// Galois step that folds in the taps when a one drops out
	function automatic mm_pkg::lfsr_t lfsr_step(mm_pkg::lfsr_t s);
		mm_pkg::lfsr_t n;
		n = s >> 1;
		if (s[0])
			n = n ^ `MM_LFSR_TAPS;
		return n;
	endfunction

	// Green count in the high three bits and yellow in the low three
	function automatic logic [5:0] score_code(mm_pkg::code_t g, mm_pkg::code_t s);
		logic [`MM_PINS-1:0] used_g;
		logic [`MM_PINS-1:0] used_s;
		int green;
		int yellow;
		used_g = '0;
		used_s = '0;
		green  = 0;
		yellow = 0;
		for (int i = 0; i < `MM_PINS; i++) begin
			if (g[i*PIN_W +: PIN_W] == s[i*PIN_W +: PIN_W]) begin
				used_g[i] = 1'b1;
				used_s[i] = 1'b1;
				green++;
			end
		end
		for (int i = 0; i < `MM_PINS; i++)
			for (int j = 0; j < `MM_PINS; j++)
				if (i != j && !used_g[i] && !used_s[j] &&
						g[i*PIN_W +: PIN_W] == s[j*PIN_W +: PIN_W]) begin
					used_g[i] = 1'b1;
					used_s[j] = 1'b1;
					yellow++;
				end
		return {3'(green), 3'(yellow)};
	endfunction

	task automatic draw_model_secret();
		for (int p = 0; p < `MM_PINS; p++) begin
			model_lfsr = lfsr_step(model_lfsr);
			model_secret[p*PIN_W +: PIN_W] = 3'(model_lfsr[7:0] % `MM_PIN_COLORS);
		end
	endtask

	task automatic check_value(string what, int got, int expected);
		if (got != expected) begin
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, expected);
			error_count++;
		end
	endtask

	task automatic press_button(int idx, bit wait_score);
		@(posedge CLK_PLL);
		btn_n[idx] <= 1'b0;
		repeat (HOLD_CYCLES) @(posedge CLK_PLL);
		btn_n[idx] <= 1'b1;
		repeat (HOLD_CYCLES) @(posedge CLK_PLL);
		@(negedge CLK_PLL);
		if (wait_score)
			while (!(guess_scored && !scoring_busy))
				@(negedge CLK_PLL);
	endtask

	task automatic read_word(int addr, output int data);
		@(posedge CLK_PLL);
		board_rd_addr <= mm_pkg::board_addr_t'(addr);
		@(posedge CLK_PLL);
		@(negedge CLK_PLL);  // Registered read has settled
		data = board_rd_data;
	endtask

	task automatic check_row(int row, mm_pkg::code_t code);
		logic [5:0] hints;
		int         data;
		hints = score_code(code, model_secret);
		for (int w = 0; w < `MM_PINS; w++) begin
			read_word(row * `MM_ROW_WORDS + w, data);
			check_value($sformatf("row %0d pin %0d", row, w), data, code[w*PIN_W +: PIN_W]);
		end
		read_word(row * `MM_ROW_WORDS + `MM_PINS, data);
		check_value($sformatf("row %0d green", row), data, hints[5:3]);
		read_word(row * `MM_ROW_WORDS + `MM_PINS + 1, data);
		check_value($sformatf("row %0d yellow", row), data, hints[2:0]);
	endtask

	task automatic test_reset();
		@(negedge CLK_PLL);
		check_value("game_state", game_state, mm_pkg::MENU);
		check_value("cursor", cursor, 0);
		check_value("guess_count", guess_count, 0);
		check_value("scoring_busy", scoring_busy, 0);
		check_value("guess_scored", guess_scored, 0);
	endtask

	task automatic test_start_game();
		draw_model_secret();
		model_guess = '0;
		press_button(`MM_BTN_ENTER, 1'b1);
		check_value("game_state", game_state, mm_pkg::GAME);
		check_row(0, model_guess);
	endtask

	task automatic test_tile_edit();
		logic [2:0] pin;
		repeat (4) press_button(`MM_BTN_RIGHT, 1'b0);
		check_value("cursor", cursor, 4);  // Tile of pin 2
		for (int k = 0; k < 7; k++) begin  // Seven presses pass the wrap
			press_button(`MM_BTN_ENTER, 1'b1);
			pin = model_guess[2*PIN_W +: PIN_W];
			pin = (pin == `MM_PIN_COLORS - 1) ? 3'd0 : pin + 3'd1;
			model_guess[2*PIN_W +: PIN_W] = pin;
			check_row(0, model_guess);
		end
		row0_guess = model_guess;
	endtask

	task automatic test_commit();
		repeat (3) press_button(`MM_BTN_LEFT, 1'b0);
		check_value("cursor", cursor, 1);
		press_button(`MM_BTN_ENTER, 1'b1);
		check_value("guess_count", guess_count, 1);
		check_row(1, model_guess);
		check_row(0, row0_guess);
	endtask

	task automatic test_exit_replay();
		press_button(`MM_BTN_LEFT, 1'b0);
		check_value("cursor", cursor, 0);
		press_button(`MM_BTN_ENTER, 1'b0);
		check_value("game_state", game_state, mm_pkg::MENU);
		draw_model_secret();  // Next four draws of the generator
		model_guess = '0;
		press_button(`MM_BTN_ENTER, 1'b1);
		check_value("guess_count", guess_count, 0);
		check_row(0, model_guess);
	endtask

	task automatic test_debounce();
		int glitch_len;
		glitch_len = 1 + ($unsigned($random(seed)) % (`MM_DEBOUNCE_CYCLES - 2));
		@(posedge CLK_PLL);
		btn_n[`MM_BTN_RIGHT] <= 1'b0;
		repeat (glitch_len) @(posedge CLK_PLL);
		btn_n[`MM_BTN_RIGHT] <= 1'b1;
		repeat (HOLD_CYCLES) @(posedge CLK_PLL);
		@(negedge CLK_PLL);
		check_value("cursor after glitch", cursor, 0);
		press_button(`MM_BTN_LEFT, 1'b0);  // Clamped at exit
		check_value("cursor after left", cursor, 0);
	endtask

	initial begin
		seed          = 34;
		error_count   = 0;
		rst_n         = 1'b0;
		btn_n         = '1;
		board_rd_addr = '0;
		model_lfsr    = `MM_LFSR_SEED;
		model_secret  = '0;
		model_guess   = '0;
		row0_guess    = '0;
		repeat (8) @(posedge CLK_PLL);
		rst_n <= 1'b1;

		test_reset();
		test_start_game();
		test_tile_edit();
		test_commit();
		test_exit_replay();
		test_debounce();

		$display("Checks done, errors: %0d", error_count);
		if (error_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/mastermind_props.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mm_consts.svh"

module mastermind_props (
	input wire                   CLK_PLL,
	input wire                   rst_n,
	input wire [1:0]             game_state,
	input wire mm_pkg::cursor_t  cursor,
	input wire                   scoring_busy,
	input wire                   guess_scored
);

	// Scored flag only after the pass has ended
	busy_not_scored: assert property (@(posedge CLK_PLL) disable iff (!rst_n)
		!(scoring_busy && guess_scored))
		else $error("scoring_busy and guess_scored are high together");

	cursor_range: assert property (@(posedge CLK_PLL) disable iff (!rst_n)
		cursor <= `MM_PINS + 1)
		else $error("cursor is beyond the last tile");

	state_legal: assert property (@(posedge CLK_PLL) disable iff (!rst_n)
		game_state inside {mm_pkg::MENU, mm_pkg::GENERATE, mm_pkg::GAME})
		else $error("game_state holds an illegal encoding");

	// No scoring pass may survive a return to the menu
	menu_idle: assert property (@(posedge CLK_PLL) disable iff (!rst_n)
		(game_state == mm_pkg::MENU) |-> !scoring_busy)
		else $error("scorer is busy while in the menu");

endmodule

bind mastermind_top mastermind_props i_mastermind_props (
	.CLK_PLL      (CLK_PLL),
	.rst_n        (rst_n),
	.game_state   (game_state),
	.cursor       (cursor),
	.scoring_busy (scoring_busy),
	.guess_scored (guess_scored)
);

`default_nettype wire

// ==== logic/mastermind_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mm_consts.svh"

module mastermind_top (
	input  wire                       CLK_PLL,
	input  wire                       rst_n,
	input  wire                       btn_left,
	input  wire                       btn_right,
	input  wire                       btn_up,
	input  wire                       btn_down,
	input  wire                       btn_enter,
	input  wire mm_pkg::board_addr_t  board_rd_addr,
	output mm_pkg::game_state_e       game_state,
	output mm_pkg::cursor_t           cursor,
	output mm_pkg::guess_count_t      guess_count,
	output logic                      scoring_busy,
	output logic                      guess_scored,
	output mm_pkg::board_word_t       board_rd_data
);

	wire [`MM_BUTTONS-1:0] btn_raw;
	wire [`MM_BUTTONS-1:0] press;
	wire                   draw_start;
	wire                   draw_done;
	mm_pkg::code_t         secret;
	logic                  wr_en;
	mm_pkg::board_addr_t   wr_addr;
	mm_pkg::board_word_t   wr_data;

	score_if sc_bus ();

	assign btn_raw[`MM_BTN_LEFT]  = btn_left;
	assign btn_raw[`MM_BTN_RIGHT] = btn_right;
	assign btn_raw[`MM_BTN_UP]    = btn_up;
	assign btn_raw[`MM_BTN_DOWN]  = btn_down;
	assign btn_raw[`MM_BTN_ENTER] = btn_enter;

	assign scoring_busy = sc_bus.busy;

	button_conditioner i_button_conditioner (
		.CLK_PLL (CLK_PLL),
		.rst_n   (rst_n),
		.btn_raw (btn_raw),
		.press   (press)
	);

	secret_generator i_secret_generator (
		.CLK_PLL    (CLK_PLL),
		.rst_n      (rst_n),
		.draw_start (draw_start),
		.draw_done  (draw_done),
		.secret     (secret)
	);

	guess_scorer i_guess_scorer (
		.CLK_PLL (CLK_PLL),
		.rst_n   (rst_n),
		.sc      (sc_bus.scorer),
		.secret  (secret),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data)
	);

	board_memory i_board_memory (
		.CLK_PLL (CLK_PLL),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_addr (board_rd_addr),
		.rd_data (board_rd_data)
	);

	game_control i_game_control (
		.CLK_PLL      (CLK_PLL),
		.rst_n        (rst_n),
		.press        (press),
		.draw_start   (draw_start),
		.draw_done    (draw_done),
		.sc           (sc_bus.ctrl),
		.game_state   (game_state),
		.cursor       (cursor),
		.guess_count  (guess_count),
		.guess_scored (guess_scored)
	);

endmodule

`default_nettype wire

// ==== logic/game_control.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mm_consts.svh"

module game_control (
	input  wire                    CLK_PLL,
	input  wire                    rst_n,
	input  wire [`MM_BUTTONS-1:0]  press,
	output logic                   draw_start,
	input  wire                    draw_done,
	score_if.ctrl                  sc,
	output mm_pkg::game_state_e    game_state,
	output mm_pkg::cursor_t        cursor,
	output mm_pkg::guess_count_t   guess_count,
	output logic                   guess_scored
);

	localparam int PIN_W = $bits(mm_pkg::pin_color_t);

	mm_pkg::code_t      guess;
	mm_pkg::pin_pos_t   tile;
	mm_pkg::pin_color_t cur_pin;
	mm_pkg::pin_color_t next_pin;
	logic               dirty;   // Guess changed, board row is stale
	logic               start_q;
	logic               enter;

	assign enter    = press[`MM_BTN_ENTER];
	assign tile     = mm_pkg::pin_pos_t'(cursor - 3'd2);
	assign cur_pin  = guess[tile*PIN_W +: PIN_W];
	assign next_pin = (cur_pin >= `MM_PIN_COLORS - 1) ? '0 : cur_pin + 1'b1;

	assign sc.start = start_q;
	assign sc.row   = guess_count;
	assign sc.guess = guess;

	always_ff @(posedge CLK_PLL or negedge rst_n) begin
		if (!rst_n) begin
			game_state   <= mm_pkg::MENU;
			cursor       <= '0;
			guess_count  <= '0;
			guess        <= '0;
			dirty        <= 1'b0;
			guess_scored <= 1'b0;
			start_q      <= 1'b0;
			draw_start   <= 1'b0;
		end else begin
			start_q    <= 1'b0;
			draw_start <= 1'b0;
			case (game_state)
				mm_pkg::MENU: begin
					if (enter) begin
						guess        <= '0;
						guess_count  <= '0;
						cursor       <= '0;
						dirty        <= 1'b0;
						guess_scored <= 1'b0;
						draw_start   <= 1'b1;
						game_state   <= mm_pkg::GENERATE;
					end
				end
				mm_pkg::GENERATE: begin
					if (draw_done) begin
						game_state <= mm_pkg::GAME;
						dirty      <= 1'b1; // First row is the blank guess
					end
				end
				mm_pkg::GAME: begin
					if (press[`MM_BTN_RIGHT] && cursor < `MM_PINS + 1)
						cursor <= cursor + 1'b1;
					else if (press[`MM_BTN_LEFT] && cursor != 0)
						cursor <= cursor - 1'b1;

					if (enter) begin
						if (cursor == 0) begin
							// Leave only with the scorer quiet
							if (!sc.busy && !start_q && !dirty)
								game_state <= mm_pkg::MENU;
						end else if (guess_scored && !sc.busy) begin
							if (cursor == 1) begin
								if (guess_count < `MM_MAX_GUESSES - 1)
									guess_count <= guess_count + 1'b1;
							end else begin
								guess[tile*PIN_W +: PIN_W] <= next_pin;
							end
							guess_scored <= 1'b0;
							dirty        <= 1'b1;
						end
					end

					if (dirty && !sc.busy) begin
						start_q      <= 1'b1;
						dirty        <= 1'b0;
						guess_scored <= 1'b0;
					end

					if (sc.done)
						guess_scored <= 1'b1;
				end
				default: game_state <= mm_pkg::MENU;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/board_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mm_consts.svh"

module board_memory (
	input  wire                       CLK_PLL,
	input  wire                       wr_en,
	input  wire mm_pkg::board_addr_t  wr_addr,
	input  wire mm_pkg::board_word_t  wr_data,
	input  wire mm_pkg::board_addr_t  rd_addr,
	output mm_pkg::board_word_t       rd_data
);

	mm_pkg::board_word_t mem [`MM_MAX_GUESSES * `MM_ROW_WORDS];

	always_ff @(posedge CLK_PLL) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		rd_data <= mem[rd_addr]; // One cycle latency
	end

endmodule

`default_nettype wire

// ==== logic/guess_scorer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mm_consts.svh"

module guess_scorer (
	input  wire                  CLK_PLL,
	input  wire                  rst_n,
	score_if.scorer              sc,
	input  wire mm_pkg::code_t   secret,
	output logic                 wr_en,
	output mm_pkg::board_addr_t  wr_addr,
	output mm_pkg::board_word_t  wr_data
);

	localparam int PIN_W = $bits(mm_pkg::pin_color_t);
	localparam int POS_W = $bits(mm_pkg::pin_pos_t);

	typedef enum logic [1:0] {
		SC_IDLE,
		SC_GREEN,
		SC_YELLOW,
		SC_WRITE
	} phase_e;

	phase_e                phase;
	logic [2*POS_W-1:0]    step;   // Yellow pass uses guess index high, secret index low
	logic [`MM_PINS-1:0]   mark_g;
	logic [`MM_PINS-1:0]   mark_s;
	mm_pkg::hint_count_t   green;
	mm_pkg::hint_count_t   yellow;
	mm_pkg::pin_pos_t      gi;
	mm_pkg::pin_pos_t      si;
	mm_pkg::pin_color_t    g_pin;
	mm_pkg::pin_color_t    s_pin;
	logic                  match;

	assign gi    = (phase == SC_YELLOW) ? step[2*POS_W-1:POS_W] : step[POS_W-1:0];
	assign si    = step[POS_W-1:0];
	assign g_pin = sc.guess[gi*PIN_W +: PIN_W];
	assign s_pin = secret[si*PIN_W +: PIN_W];
	assign match = (g_pin == s_pin) && !mark_g[gi] && !mark_s[si];

	assign sc.busy = (phase != SC_IDLE);

	// Row write, one word per cycle
	assign wr_en   = (phase == SC_WRITE);
	assign wr_addr = mm_pkg::board_addr_t'(sc.row * `MM_ROW_WORDS + step);
	always_comb begin
		if (step < `MM_PINS)
			wr_data = mm_pkg::board_word_t'(g_pin);
		else if (step == `MM_PINS)
			wr_data = mm_pkg::board_word_t'(green);
		else
			wr_data = mm_pkg::board_word_t'(yellow);
	end

	always_ff @(posedge CLK_PLL or negedge rst_n) begin
		if (!rst_n) begin
			phase   <= SC_IDLE;
			step    <= '0;
			mark_g  <= '0;
			mark_s  <= '0;
			green   <= '0;
			yellow  <= '0;
			sc.done <= 1'b0;
		end else begin
			sc.done <= 1'b0;
			case (phase)
				SC_IDLE: begin
					if (sc.start) begin
						phase  <= SC_GREEN;
						step   <= '0;
						mark_g <= '0;
						mark_s <= '0;
						green  <= '0;
						yellow <= '0;
					end
				end
				SC_GREEN: begin
					if (match) begin
						mark_g[gi] <= 1'b1;
						mark_s[si] <= 1'b1;
						green      <= green + 1'b1;
					end
					if (step == `MM_PINS - 1) begin
						phase <= SC_YELLOW;
						step  <= '0;
					end else begin
						step <= step + 1'b1;
					end
				end
				SC_YELLOW: begin
					if (match && gi != si) begin // Same index was settled by green
						mark_g[gi] <= 1'b1;
						mark_s[si] <= 1'b1;
						yellow     <= yellow + 1'b1;
					end
					if (step == `MM_PINS * `MM_PINS - 1) begin
						phase <= SC_WRITE;
						step  <= '0;
					end else begin
						step <= step + 1'b1;
					end
				end
				SC_WRITE: begin
					if (step == `MM_PINS + 1) begin
						phase   <= SC_IDLE;
						step    <= '0;
						sc.done <= 1'b1;
					end else begin
						step <= step + 1'b1;
					end
				end
				default: phase <= SC_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/secret_generator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mm_consts.svh"

module secret_generator (
	input  wire            CLK_PLL,
	input  wire            rst_n,
	input  wire            draw_start,
	output logic           draw_done,
	output mm_pkg::code_t  secret
);

	localparam int PIN_W = $bits(mm_pkg::pin_color_t);

	mm_pkg::lfsr_t      lfsr;
	mm_pkg::lfsr_t      lfsr_next;
	mm_pkg::pin_pos_t   pin_cnt;
	mm_pkg::pin_color_t pin_color;
	logic               active;

	// Shift right, fold the taps back in when a one drops out
	always_comb begin
		lfsr_next = lfsr >> 1;
		if (lfsr[0])
			lfsr_next = lfsr_next ^ `MM_LFSR_TAPS;
	end

	assign pin_color = mm_pkg::pin_color_t'(lfsr_next[7:0] % `MM_PIN_COLORS);

	always_ff @(posedge CLK_PLL or negedge rst_n) begin
		if (!rst_n) begin
			lfsr      <= `MM_LFSR_SEED; // Kept across games
			pin_cnt   <= '0;
			active    <= 1'b0;
			draw_done <= 1'b0;
		end else begin
			draw_done <= 1'b0;
			if (draw_start) begin
				active  <= 1'b1;
				pin_cnt <= '0;
			end else if (active) begin
				lfsr    <= lfsr_next;
				pin_cnt <= pin_cnt + 1'b1;
				if (pin_cnt == mm_pkg::pin_pos_t'(`MM_PINS - 1)) begin
					active    <= 1'b0;
					draw_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge CLK_PLL) begin
		if (active)
			secret[pin_cnt*PIN_W +: PIN_W] <= pin_color;
	end

endmodule

`default_nettype wire

// ==== logic/button_conditioner.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mm_consts.svh"

module button_conditioner (
	input  wire                     CLK_PLL,
	input  wire                     rst_n,
	input  wire [`MM_BUTTONS-1:0]   btn_raw, // Active low
	output logic [`MM_BUTTONS-1:0]  press
);

	localparam int CNT_W = $clog2(`MM_DEBOUNCE_CYCLES);

	logic [`MM_BUTTONS-1:0] btn_q;   // Sampled, pressed is high
	logic [`MM_BUTTONS-1:0] deb;
	logic [`MM_BUTTONS-1:0] deb_d;
	logic [CNT_W-1:0]       cnt [`MM_BUTTONS];

	always_ff @(posedge CLK_PLL or negedge rst_n) begin
		if (!rst_n) begin
			btn_q <= '0;
			deb   <= '0;
			deb_d <= '0;
			for (int i = 0; i < `MM_BUTTONS; i++)
				cnt[i] <= '0;
		end else begin
			btn_q <= ~btn_raw;
			deb_d <= deb;
			for (int i = 0; i < `MM_BUTTONS; i++) begin
				if (btn_q[i] == deb[i]) begin
					cnt[i] <= '0; // Glitch over, start again
				end else if (cnt[i] == CNT_W'(`MM_DEBOUNCE_CYCLES - 1)) begin
					deb[i] <= btn_q[i];
					cnt[i] <= '0;
				end else begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
		end
	end

	assign press = deb & ~deb_d; // Released to pressed only

endmodule

`default_nettype wire

// ==== logic/score_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface score_if;

	logic                  start; // Pulse, only while busy is low
	mm_pkg::guess_count_t  row;
	mm_pkg::code_t         guess; // Stable while busy
	logic                  busy;
	logic                  done;  // One cycle at the end of the pass

	modport ctrl (output start, output row, output guess, input busy, input done);

	modport scorer (input start, input row, input guess, output busy, output done);

endinterface

`default_nettype wire

// ==== logic/mm_pkg.sv ====
`default_nettype none

`include "mm_consts.svh"

package mm_pkg;

	typedef logic [2:0]  pin_color_t;
	typedef logic [$clog2(`MM_PINS)-1:0] pin_pos_t;
	typedef logic [`MM_PINS*$bits(pin_color_t)-1:0] code_t; // Pin 0 in the low bits
	typedef logic [2:0]  hint_count_t;
	typedef logic [4:0]  guess_count_t;
	typedef logic [2:0]  cursor_t;     // 0 exit, 1 commit, 2.. tiles
	typedef logic [6:0]  board_addr_t;
	typedef logic [7:0]  board_word_t;
	typedef logic [31:0] lfsr_t;

	typedef enum logic [1:0] {
		MENU,
		GENERATE,
		GAME
	} game_state_e;

endpackage

`default_nettype wire

// ==== logic/mm_consts.svh ====
`ifndef MM_CONSTS_SVH
`define MM_CONSTS_SVH

// Game size
`define MM_PINS            4
`define MM_PIN_COLORS      6
`define MM_MAX_GUESSES     16
`define MM_ROW_WORDS       8   // Pins, green, yellow, spare

// Buttons and their bit positions in the press vector
`define MM_BUTTONS         5
`define MM_BTN_LEFT        0
`define MM_BTN_RIGHT       1
`define MM_BTN_UP          2
`define MM_BTN_DOWN        3
`define MM_BTN_ENTER       4
`define MM_DEBOUNCE_CYCLES 16

// Galois LFSR
`define MM_LFSR_SEED       32'hACE1_2468
`define MM_LFSR_TAPS       32'h8020_0003

`endif
